// File: flist.f
source/axil_wb_pkg.sv
source/axil_rd_bridge.sv
source/wb_rd_rom.sv
source/axil_wb_rd_top.sv
test/rd_checker.sv
test/tb_axil_wb_rd.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI-lite read bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f \
	--top-module tb_axil_wb_rd -o tb_axil_wb_rd

sim_out=$(./obj_dir/tb_axil_wb_rd)
echo "$sim_out"

if echo "$sim_out" | grep -q "All tests passed!"; then
	exit 0
fi
exit 1

// File: source/rom_init.hex
// One 32-bit word per line, word address 0 to 63
// Bytes from the top: address, inverted address, 3C, address xor A5
00FF3CA5
01FE3CA4
02FD3CA7
03FC3CA6
04FB3CA1
05FA3CA0
06F93CA3
07F83CA2
08F73CAD
09F63CAC
0AF53CAF
0BF43CAE
0CF33CA9
0DF23CA8
0EF13CAB
0FF03CAA
10EF3CB5
11EE3CB4
12ED3CB7
13EC3CB6
14EB3CB1
15EA3CB0
16E93CB3
17E83CB2
18E73CBD
19E63CBC
1AE53CBF
1BE43CBE
1CE33CB9
1DE23CB8
1EE13CBB
1FE03CBA
20DF3C85
21DE3C84
22DD3C87
23DC3C86
24DB3C81
25DA3C80
26D93C83
27D83C82
28D73C8D
29D63C8C
2AD53C8F
2BD43C8E
2CD33C89
2DD23C88
2ED13C8B
2FD03C8A
30CF3C95
31CE3C94
32CD3C97
33CC3C96
34CB3C91
35CA3C90
36C93C93
37C83C92
38C73C9D
39C63C9C
3AC53C9F
3BC43C9E
3CC33C99
3DC23C98
3EC13C9B
3FC03C9A

// File: test/tb_axil_wb_rd.sv
/*
 * Testbench for the AXI-lite read bridge with its Wishbone ROM
 * Directed reads, back-pressure, error flush and a long random run
 */
`timescale 1ns/1ns
`default_nettype none

module tb_axil_wb_rd;
	import axil_wb_pkg::*;

	localparam int TIMEOUT_CYCLES = 200;
	localparam int RANDOM_READS = 400;

	logic      clk;
	logic      axi_reset_n;
	logic      ar_valid;
	logic      ar_ready;
	axi_addr_t ar_addr;
	logic      r_valid;
	logic      r_ready;
	axil_r_t   r_data;
	int        seed = 32'h9c22_2200;
	// 0 holds ready low, 1 holds it high, 2 makes it random
	int        ready_mode = 0;
	int        errors_seen;
	int        accepted;
	int        returned;
	int        timeouts = 0;

	axil_wb_rd_top u_dut (
		.i_clk         (clk),
		.i_axi_reset_n (axi_reset_n),
		.i_ar_valid    (ar_valid),
		.o_ar_ready    (ar_ready),
		.i_ar_addr     (ar_addr),
		.o_r_valid     (r_valid),
		.i_r_ready     (r_ready),
		.o_r           (r_data)
	);

	rd_checker u_checker (
		.i_clk      (clk),
		.i_reset    (!axi_reset_n),
		.i_ar_valid (ar_valid),
		.i_ar_ready (ar_ready),
		.i_ar_addr  (ar_addr),
		.i_r_valid  (r_valid),
		.i_r_ready  (r_ready),
		.i_r        (r_data),
		.o_errors   (errors_seen),
		.o_accepted (accepted),
		.o_returned (returned)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Read-data ready changes only on the rising edge
	initial
	begin
		int r;
		int mode_now;
		r_ready = 1'b0;
		forever
		begin
			// Draw and mode taken mid-cycle, apart from the address driver
			@(negedge clk);
			r = $random(seed);
			mode_now = ready_mode;
			@(posedge clk);
			if (!axi_reset_n)
				r_ready <= 1'b0;
			else
				case (mode_now)
				0: r_ready <= 1'b0;
				1: r_ready <= 1'b1;
				default: r_ready <= (r[1:0] != 2'b00);
				endcase
		end
	end

	task automatic finish_run();
		$display("Reads accepted %0d, returned %0d, errors %0d, timeouts %0d",
			accepted, returned, errors_seen, timeouts);
		if (errors_seen == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	endtask

	task automatic abort_run(input string what);
		$display("Timeout waiting for %s", what);
		timeouts++;
		finish_run();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Address channel driver
	////////////////////////////////////////////////////////////////////////////

	// Called just after a rising edge and returns on the edge of the transfer
	task automatic send_read(input axi_addr_t addr);
		int waited;
		waited = 0;
		ar_valid <= 1'b1;
		ar_addr <= addr;
		@(negedge clk);
		while (!ar_ready && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(negedge clk);
		end
		if (!ar_ready)
			abort_run("the read address channel");
		else
		begin
			@(posedge clk);
			ar_valid <= 1'b0;
		end
	endtask

	// Mostly in range with about one in sixteen past the ROM
	task automatic send_random_read();
		int       r;
		wb_addr_t word;
		r = $random(seed);
		if (r[3:0] == 4'h0)
		begin
			word = wb_addr_t'(r[17:8]);
			if (word < wb_addr_t'(ROM_DEPTH))
				word = word + wb_addr_t'(ROM_DEPTH);
		end
		else
			word = wb_addr_t'(r[13:8]);
		// Occasional idle cycle on the address channel
		if (r[5:4] == 2'b00)
			@(posedge clk);
		send_read({word, 2'b00});
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (accepted != returned && waited < TIMEOUT_CYCLES)
		begin
			waited++;
			@(posedge clk);
		end
		if (accepted != returned)
			abort_run("outstanding responses to drain");
	endtask

	initial
	begin
		axi_reset_n = 1'b0;
		ar_valid = 1'b0;
		ar_addr = '0;
		repeat (4) @(posedge clk);
		axi_reset_n <= 1'b1;
		@(posedge clk);

		// Back to back in range with ready high
		ready_mode = 1;
		for (int i = 0; i < 16; i++)
			send_read(axi_addr_t'(i * 4));
		wait_drain();

		// Fill the FIFO, then one more read waits on ready
		ready_mode = 0;
		@(posedge clk);
		for (int i = 0; i < 8; i++)
			send_read(axi_addr_t'((20 + i) * 4));
		fork
			send_read(axi_addr_t'(40 * 4));
			begin
				repeat (20) @(posedge clk);
				ready_mode = 1;
			end
		join
		wait_drain();

		// Errors with reads queued behind them
		send_read(12'h010);
		send_read(12'h400);
		send_read(12'h014);
		send_read(12'h018);
		send_read(12'h01c);
		send_read(12'hffc);
		send_read(12'h020);
		wait_drain();

		// Clean reads after the flush
		for (int i = 0; i < 8; i++)
			send_read(axi_addr_t'(i * 8 + 4));
		wait_drain();

		// Long random run
		ready_mode = 2;
		for (int i = 0; i < RANDOM_READS; i++)
			send_random_read();
		ready_mode = 1;
		wait_drain();
		finish_run();
	end

endmodule

`default_nettype wire

// File: test/rd_checker.sv
/*
 * Response checker for the AXI-lite read bridge
 * Models the ROM and the error flush, and compares every returned read
 */
`timescale 1ns/1ns
`default_nettype none

module rd_checker (
	input  wire logic                   i_clk,
	input  wire logic                   i_reset,
	input  wire logic                   i_ar_valid,
	input  wire logic                   i_ar_ready,
	input  wire axil_wb_pkg::axi_addr_t i_ar_addr,
	input  wire logic                   i_r_valid,
	input  wire logic                   i_r_ready,
	input  wire axil_wb_pkg::axil_r_t   i_r,
	output int                          o_errors,
	output int                          o_accepted,
	output int                          o_returned
);
	import axil_wb_pkg::*;

	data_t     model_mem [0:ROM_DEPTH-1];
	// Reads accepted but not yet returned, oldest first
	axi_addr_t addr_q[$];
	bit        behind_q[$];
	int        errors = 0;
	int        accepted = 0;
	int        returned = 0;
	logic      was_reset = 1'b1;
	// Payload seen while valid waited on ready
	logic      hold_pending = 1'b0;
	axil_r_t   held_r;

	assign o_errors = errors;
	assign o_accepted = accepted;
	assign o_returned = returned;

	initial
		$readmemh("source/rom_init.hex", model_mem);

	function automatic logic out_of_range(input axi_addr_t addr);
		return addr[AXI_ADDR_W-1:2] >= wb_addr_t'(ROM_DEPTH);
	endfunction

	// Expected response: flushed, failing, or a plain ROM word
	function automatic axil_r_t expected_resp(input axi_addr_t addr, input bit behind_err);
		axil_r_t exp_r;
		exp_r.data = '0;
		if (behind_err)
			exp_r.resp = RESP_DECERR;
		else if (out_of_range(addr))
			exp_r.resp = RESP_SLVERR;
		else
		begin
			exp_r.resp = RESP_OKAY;
			exp_r.data = model_mem[addr[ROM_AW+1:2]];
		end
		return exp_r;
	endfunction

	task automatic value_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		$display("Fail %s got %h expected %h", name, got, exp);
		errors++;
	endtask

	task automatic protocol_error(input string what);
		$display("Error at %0t ns: %s", $time, what);
		errors++;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare process, sampled mid-cycle where everything is settled
	////////////////////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		axil_r_t exp_r;
		bit      behind;
		if (i_reset)
		begin
			was_reset = 1'b1;
			hold_pending = 1'b0;
		end
		else
		begin
			// First cycle out of reset
			if (was_reset)
			begin
				if (i_ar_ready !== 1'b1)
					value_mismatch("o_ar_ready", 64'(i_ar_ready), 64'(1'b1));
				if (i_r_valid !== 1'b0)
					value_mismatch("o_r_valid", 64'(i_r_valid), 64'(1'b0));
				was_reset = 1'b0;
			end
			// Stalled payload must not move
			if (hold_pending)
			begin
				if (i_r_valid !== 1'b1)
					protocol_error("r_valid dropped before the response was taken");
				else if (i_r !== held_r)
					value_mismatch("o_r", 64'(i_r), 64'(held_r));
			end
			hold_pending = i_r_valid && !i_r_ready;
			held_r = i_r;
			// Returned read
			if (i_r_valid && i_r_ready)
			begin
				if (addr_q.size() == 0)
					protocol_error("response returned with no read outstanding");
				else
				begin
					exp_r = expected_resp(addr_q[0], behind_q[0]);
					void'(addr_q.pop_front());
					void'(behind_q.pop_front());
					returned++;
					if (i_r.resp !== exp_r.resp)
						value_mismatch("o_r.resp", 64'(i_r.resp), 64'(exp_r.resp));
					else if (exp_r.resp == RESP_OKAY && i_r.data !== exp_r.data)
						value_mismatch("o_r.data", 64'(i_r.data), 64'(exp_r.data));
				end
			end
			// Accepted read, flushed if a bad one is still queued ahead
			if (i_ar_valid && i_ar_ready)
			begin
				behind = 1'b0;
				foreach (addr_q[k])
					if (out_of_range(addr_q[k]))
						behind = 1'b1;
				addr_q.push_back(i_ar_addr);
				behind_q.push_back(behind);
				accepted++;
				if (addr_q.size() > FIFO_DEPTH)
					protocol_error("more than eight reads in flight");
			end
		end
	end

endmodule

`default_nettype wire

// File: source/axil_wb_rd_top.sv
/*
 * AXI-lite read bridge joined to its Wishbone ROM
 * Also turns the active-low AXI reset into the internal reset
 */
`timescale 1ns/1ns
`default_nettype none

module axil_wb_rd_top (
	input  wire logic                   i_clk,
	input  wire logic                   i_axi_reset_n,
	// Read address channel
	input  wire logic                   i_ar_valid,
	output logic                        o_ar_ready,
	input  wire axil_wb_pkg::axi_addr_t i_ar_addr,
	// Read data channel
	output logic                        o_r_valid,
	input  wire logic                   i_r_ready,
	output axil_wb_pkg::axil_r_t        o_r
);
	import axil_wb_pkg::*;

	// Active high, sampled on the clock inside both blocks
	logic    w_reset;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;

	assign w_reset = !i_axi_reset_n;

	axil_rd_bridge u_bridge (
		.i_clk      (i_clk),
		.i_reset    (w_reset),
		.i_ar_valid (i_ar_valid),
		.o_ar_ready (o_ar_ready),
		.i_ar_addr  (i_ar_addr),
		.o_wb       (wb_req),
		.i_wb       (wb_rsp),
		.o_r_valid  (o_r_valid),
		.i_r_ready  (i_r_ready),
		.o_r        (o_r)
	);

	// Read target
	wb_rd_rom u_rom (
		.i_clk   (i_clk),
		.i_reset (w_reset),
		.i_wb    (wb_req),
		.o_wb    (wb_rsp)
	);

endmodule

`default_nettype wire

// File: source/wb_rd_rom.sv
/*
 * Wishbone pipelined read-only memory
 * Stalls in a pseudo-random pattern and answers two cycles after each
 * accepted request, with an error for addresses past its depth
 */
`timescale 1ns/1ns
`default_nettype none

module wb_rd_rom (
	input  wire logic                 i_clk,
	input  wire logic                 i_reset,
	input  wire axil_wb_pkg::wb_req_t i_wb,
	output axil_wb_pkg::wb_rsp_t      o_wb
);
	import axil_wb_pkg::*;

	data_t       rom_mem [0:ROM_DEPTH-1];
	logic [15:0] lfsr;
	logic        lfsr_fb;
	logic        stall;
	logic        req_fire;
	// Two response stages of valid, out of range flag and word
	logic        v1, v2;
	logic        oor1, oor2;
	data_t       word1, word2;

	initial
		$readmemh("source/rom_init.hex", rom_mem);

	// Taps 16, 14, 13, 11
	assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			lfsr <= 16'hace1;
		else
			lfsr <= {lfsr[14:0], lfsr_fb};
	end

	// Roughly one cycle in four
	assign stall = lfsr[0] && lfsr[4];
	assign req_fire = i_wb.cyc && i_wb.stb && !stall;

	// Dropping cyc kills whatever is in flight
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end
		else
		begin
			v1 <= req_fire;
			v2 <= v1 && i_wb.cyc;
		end
	end

	always_ff @(posedge i_clk)
	begin
		oor1 <= (i_wb.addr >= wb_addr_t'(ROM_DEPTH));
		word1 <= rom_mem[i_wb.addr[ROM_AW-1:0]];
		oor2 <= oor1;
		word2 <= word1;
	end

	assign o_wb = '{
		stall: stall,
		ack: v2 && !oor2 && i_wb.cyc,
		err: v2 && oor2 && i_wb.cyc,
		data: word2
	};

	a_one_answer: assert property (@(posedge i_clk) disable iff (i_reset)
		!(o_wb.ack && o_wb.err));

endmodule

`default_nettype wire

// File: source/axil_rd_bridge.sv
/*
 * AXI-lite read to pipelined Wishbone bridge
 * Issues reads as stall-aware strobes, keeps up to eight in flight and
 * returns them in order, flushing with error responses after a bus error
 */
`timescale 1ns/1ns
`default_nettype none

module axil_rd_bridge (
	input  wire logic                   i_clk,
	input  wire logic                   i_reset,
	// Read address channel
	input  wire logic                   i_ar_valid,
	output logic                        o_ar_ready,
	input  wire axil_wb_pkg::axi_addr_t i_ar_addr,
	// Wishbone master side
	output axil_wb_pkg::wb_req_t        o_wb,
	input  wire axil_wb_pkg::wb_rsp_t   i_wb,
	// Read data channel
	output logic                        o_r_valid,
	input  wire logic                   i_r_ready,
	output axil_wb_pkg::axil_r_t        o_r
);
	import axil_wb_pkg::*;

	// Pointers into the FIFO: accepted, answered, returned
	fifo_ptr_t    r_first, r_mid, r_last;
	fifo_ptr_t    fifo_fill;
	fifo_ptr_t    wb_outstanding;
	// Slot of the read that failed, and how far the output is from it
	fifo_ptr_t    err_loc;
	fifo_ptr_t    err_dist;
	data_t        dfifo [0:FIFO_DEPTH-1];
	bridge_mode_t mode;
	resp_t        rd_resp;

	logic     wb_cyc;
	logic     wb_stb;
	wb_addr_t wb_addr;
	// Shadow request, parked while the live strobe is stalled
	logic     r_stb;
	wb_addr_t r_addr;
	wb_addr_t ar_word;

	logic ar_fire, r_fire, wb_fire, wb_done, wb_fail;

	assign ar_fire = i_ar_valid && o_ar_ready;
	assign r_fire = o_r_valid && i_r_ready;
	assign wb_fire = wb_stb && !i_wb.stall;
	assign wb_done = wb_cyc && (i_wb.ack || i_wb.err);
	assign wb_fail = wb_cyc && i_wb.err;
	// Drop the two byte bits
	assign ar_word = i_ar_addr[AXI_ADDR_W-1:2];
	assign fifo_fill = r_first - r_last;

	////////////////////////////////////////////////////////////////////////////
	// Wishbone request side
	////////////////////////////////////////////////////////////////////////////

	// Strobe dies at once on a bus error and stays down in flush
	always_ff @(posedge i_clk)
	begin
		if (i_reset || wb_fail || mode == MODE_FLUSH)
			wb_stb <= 1'b0;
		else if (r_stb || ar_fire)
			wb_stb <= 1'b1;
		else if (!i_wb.stall)
			wb_stb <= 1'b0;
	end

	// Shadow goes first once the bus takes the live request
	always_ff @(posedge i_clk)
	begin
		if (r_stb && !i_wb.stall)
			wb_addr <= r_addr;
		else if (ar_fire && (!wb_stb || !i_wb.stall))
			wb_addr <= ar_word;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset || wb_fail || mode == MODE_FLUSH)
			r_stb <= 1'b0;
		else if (ar_fire && wb_stb && i_wb.stall)
			r_stb <= 1'b1;
		else if (!i_wb.stall)
			r_stb <= 1'b0;
	end

	always_ff @(posedge i_clk)
	begin
		if (ar_fire && wb_stb && i_wb.stall)
			r_addr <= ar_word;
	end

	// Requests on the bus still waiting for ack
	always_ff @(posedge i_clk)
	begin
		if (i_reset || !wb_cyc || i_wb.err || mode == MODE_FLUSH)
			wb_outstanding <= '0;
		else
			case ({wb_fire, i_wb.ack})
			2'b01: wb_outstanding <= wb_outstanding - fifo_ptr_t'(1);
			2'b10: wb_outstanding <= wb_outstanding + fifo_ptr_t'(1);
			default: wb_outstanding <= wb_outstanding;
			endcase
	end

	assign wb_cyc = wb_stb || (wb_outstanding != '0);
	assign o_wb = '{cyc: wb_cyc, stb: wb_stb, addr: wb_addr};

	////////////////////////////////////////////////////////////////////////////
	// Address channel ready
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			o_ar_ready <= 1'b1;
		else if (wb_fail || mode == MODE_FLUSH)
			o_ar_ready <= 1'b0;
		// Second request lands in the shadow
		else if (ar_fire && wb_stb && i_wb.stall)
			o_ar_ready <= 1'b0;
		// Shadow still waiting on the bus
		else if (!o_ar_ready && wb_stb && i_wb.stall)
			o_ar_ready <= 1'b0;
		else if (fifo_fill == fifo_ptr_t'(FIFO_DEPTH) && !r_fire)
			o_ar_ready <= 1'b0;
		// Last free slot just taken
		else if (ar_fire && !r_fire)
			o_ar_ready <= (fifo_fill != fifo_ptr_t'(FIFO_DEPTH - 1));
		else
			o_ar_ready <= 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// FIFO pointers, storage and mode
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			r_first <= '0;
			r_last <= '0;
		end
		else
		begin
			if (ar_fire)
				r_first <= r_first + fifo_ptr_t'(1);
			if (r_fire)
				r_last <= r_last + fifo_ptr_t'(1);
		end
	end

	// In flush the unanswered slots count as answered
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
			r_mid <= '0;
		else if (wb_done)
			r_mid <= r_mid + fifo_ptr_t'(1);
		else if (mode == MODE_FLUSH)
			r_mid <= r_first;
	end

	always_ff @(posedge i_clk)
	begin
		if (wb_done)
			dfifo[r_mid[LGFIFO-1:0]] <= i_wb.data;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			mode <= MODE_RUN;
			err_loc <= '0;
		end
		else
		begin
			// Back to run once every accepted read is returned
			if (r_first == r_last)
				mode <= MODE_RUN;
			else if (wb_fail)
				mode <= MODE_FLUSH;
			if (wb_fail)
				err_loc <= r_mid;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data channel
	////////////////////////////////////////////////////////////////////////////

	// Zero means the failing slot, top bit set means behind it
	assign err_dist = err_loc - r_last;

	always_comb
	begin
		if (mode != MODE_FLUSH || (err_dist != '0 && !err_dist[LGFIFO]))
			rd_resp = RESP_OKAY;
		else if (err_dist == '0)
			rd_resp = RESP_SLVERR;
		else
			rd_resp = RESP_DECERR;
	end

	assign o_r_valid = (mode == MODE_FLUSH) ? (r_first != r_last) : (r_mid != r_last);
	assign o_r = '{
		data: (rd_resp == RESP_OKAY) ? dfifo[r_last[LGFIFO-1:0]] : '0,
		resp: rd_resp
	};

	// Flush keeps both the bus and the address channel quiet
	a_flush_quiet: assert property (@(posedge i_clk) disable iff (i_reset)
		(mode == MODE_FLUSH) |-> (!o_ar_ready && !wb_cyc));

	a_fill_max: assert property (@(posedge i_clk) disable iff (i_reset)
		fifo_fill <= fifo_ptr_t'(FIFO_DEPTH));

	a_full_blocks: assert property (@(posedge i_clk) disable iff (i_reset)
		(fifo_fill == fifo_ptr_t'(FIFO_DEPTH)) |-> !o_ar_ready);

endmodule

`default_nettype wire

// File: source/axil_wb_pkg.sv
/*
 * Shared definitions for the AXI-lite read to Wishbone bridge and its ROM
 * Bus widths, FIFO and ROM sizes, vector types and the bus structs
 */
`default_nettype none

package axil_wb_pkg;

	// Bus widths
	localparam int AXI_ADDR_W = 12;
	localparam int DATA_W = 32;
	localparam int WB_ADDR_W = 10;

	// Reads in flight, as a power of two
	localparam int LGFIFO = 3;
	localparam int FIFO_DEPTH = 1 << LGFIFO;

	// ROM size in words
	localparam int ROM_DEPTH = 64;
	localparam int ROM_AW = $clog2(ROM_DEPTH);

	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [WB_ADDR_W-1:0]  wb_addr_t;
	typedef logic [DATA_W-1:0]     data_t;
	// Extra top bit tells a full FIFO from an empty one
	typedef logic [LGFIFO:0]       fifo_ptr_t;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} resp_t;

	typedef enum logic {
		MODE_RUN   = 1'b0,
		MODE_FLUSH = 1'b1
	} bridge_mode_t;

	// Wishbone master to slave
	typedef struct packed {
		logic     cyc;
		logic     stb;
		wb_addr_t addr;
	} wb_req_t;

	// Wishbone slave to master
	typedef struct packed {
		logic  stall;
		logic  ack;
		logic  err;
		data_t data;
	} wb_rsp_t;

	// AXI-lite read data payload
	typedef struct packed {
		data_t data;
		resp_t resp;
	} axil_r_t;

endpackage

`default_nettype wire
